// File: dv/fetch_mem_model.sv
/*
 * Instruction memory model
 * Answers fetch reads in order after a per-phase delay and returns
 * one request credit with each response
 */
`timescale 1ns/1ps
`include "fetch_defs.svh"

module fetch_mem_model
  import mem_pkg::*;
#(
  parameter int IMG_WORDS = 128
) (
  input  logic      clk,
  input  logic      arst_n,
  input  int        delay,
  input  logic      mem_req_val,
  input  mem_req_t  mem_req,
  output logic      mem_credit,
  output logic      mem_resp_val,
  output mem_resp_t mem_resp,
  output int        outstanding,
  output logic      op_err
);

  localparam int IDX_BITS = $clog2(IMG_WORDS);

  // Image written by the testbench before reset release
  logic [31:0] img [IMG_WORDS];

  // --------------------------------------------------
  // Outstanding requests, oldest first
  // --------------------------------------------------
  logic [MEM_OPAQ_BITS-1:0] tag_q [$];
  logic [31:0]              addr_q [$];
  longint                   due_q [$];
  longint                   cyc;
  logic [MEM_OPAQ_BITS-1:0] head_tag;
  logic [31:0]              head_addr;

  // Word offset from the reset PC, wraps on the image
  function automatic logic [31:0] read_word(input logic [31:0] addr);
    logic [31:0] off;
    off = (addr - `FETCH_RESET_PC) >> 2;
    return img[off[IDX_BITS-1:0]];
  endfunction

  initial begin
    mem_credit   = 1'b0;
    mem_resp_val = 1'b0;
    mem_resp     = '0;
    outstanding  = 0;
    op_err       = 1'b0;
    cyc          = 0;
  end

  // Requests seen here fire on the next rising edge
  always @(negedge clk) begin
    if (!arst_n) begin
      mem_credit   = 1'b0;
      mem_resp_val = 1'b0;
      mem_resp     = '0;
      op_err       = 1'b0;
      tag_q.delete();
      addr_q.delete();
      due_q.delete();
      cyc = 0;
    end else begin
      mem_credit   = 1'b0;
      mem_resp_val = 1'b0;
      // One response per cycle, head only
      if (due_q.size() != 0 && due_q[0] <= cyc) begin
        head_tag      = tag_q.pop_front();
        head_addr     = addr_q.pop_front();
        void'(due_q.pop_front());
        mem_resp.opaq = head_tag;
        mem_resp.data = read_word(head_addr);
        mem_resp_val  = 1'b1;
        // Credit goes back with the data
        mem_credit    = 1'b1;
      end
      if (mem_req_val) begin
        if (mem_req.op != MEM_READ) begin
          op_err = 1'b1;
        end
        tag_q.push_back(mem_req.opaq);
        addr_q.push_back(mem_req.addr);
        due_q.push_back(cyc + longint'((delay < 1) ? 1 : delay));
      end
      outstanding = due_q.size();
      cyc = cyc + 1;
    end
  end

endmodule

// File: dv/fetch_trace.txt
// fetch_unit testbench trace, all values hex
// @00 phase count, @01 number of image words given at @40
// @02 + 4*p per phase: instr count, mem delay, decode credit gap, commit gap
// @40 memory image from FETCH_RESET_PC, one word per line, rest filled at random
@00
4
10
// Phase 0: single-cycle memory, credits and commits at full rate
14 1 0 0
// Phase 1: slow memory, decode credits late
10 5 3 0
// Phase 2: commits held back long enough to use up the sequence numbers
20 2 0 18
// Phase 3: mixed pacing
14 3 1 2
@40
00000013
00100093
00200113
002081b3
40110233
0041a2b3
00512333
00300393
00729463
0073e433
fff40493
00a4f533
00551593
0015d613
00c6a6b3
0000006f

// File: dv/fetch_unit_tb.sv
/*
 * Fetch unit testbench
 * Reads the trace, drives decode credits and commits, checks each
 * decoded instruction against the image and the pacing limits
 */
`timescale 1ns/1ps
`include "fetch_defs.svh"

module fetch_unit_tb
  import mem_pkg::*;
#(
  parameter int SEQ_NUM_BITS = `FETCH_SEQ_NUM_BITS,
  parameter int MEM_CREDITS  = `FETCH_MEM_CREDITS,
  parameter int DEC_CREDITS  = `FETCH_DEC_CREDITS
);

  localparam int TRACE_WORDS = 256;
  localparam int IMG_BASE    = 'h40;
  localparam int IMG_WORDS   = 128;
  localparam int MAX_PHASES  = 8;
  localparam int SEQ_SPACE   = 2 ** SEQ_NUM_BITS;

  typedef `FETCH_F2D_T(SEQ_NUM_BITS)    f2d_t;
  typedef `FETCH_COMMIT_T(SEQ_NUM_BITS) commit_t;

  logic      clk;
  logic      arst_n;
  logic      mem_req_val;
  mem_req_t  mem_req;
  logic      mem_credit;
  logic      mem_resp_val;
  mem_resp_t mem_resp;
  logic      dec_val;
  f2d_t      dec_msg;
  logic      dec_credit = 1'b0;
  logic      commit_val = 1'b0;
  commit_t   commit_msg = '0;
  int        outstanding;
  logic      op_err;

  // Trace contents and per-phase pacing
  logic [31:0] trace_mem [TRACE_WORDS];
  int          ph_end   [MAX_PHASES];
  int          ph_delay [MAX_PHASES];
  int          ph_dgap  [MAX_PHASES];
  int          ph_cgap  [MAX_PHASES];
  int          n_phases = 0;
  int          total = 0;
  int          limit = 0;
  int          phase = 0;
  int          mem_delay = 1;

  // Decode and commit bookkeeping
  int                      dec_cnt = 0;
  int                      com_cnt = 0;
  int                      req_cnt = 0;
  int                      cred_back = 0;
  int                      cred_owed = 0;
  int                      dgap_cnt = 0;
  int                      cgap_cnt = 0;
  logic [SEQ_NUM_BITS-1:0] commit_q [$];

  fetch_unit #(
    .SEQ_NUM_BITS (SEQ_NUM_BITS),
    .MEM_CREDITS  (MEM_CREDITS),
    .DEC_CREDITS  (DEC_CREDITS)
  ) dut_i (
    .clk          (clk),
    .arst_n       (arst_n),
    .mem_req_val  (mem_req_val),
    .mem_req      (mem_req),
    .mem_credit   (mem_credit),
    .mem_resp_val (mem_resp_val),
    .mem_resp     (mem_resp),
    .dec_val      (dec_val),
    .dec_msg      (dec_msg),
    .dec_credit   (dec_credit),
    .commit_val   (commit_val),
    .commit_msg   (commit_msg)
  );

  fetch_mem_model #(
    .IMG_WORDS (IMG_WORDS)
  ) mem_i (
    .clk          (clk),
    .arst_n       (arst_n),
    .delay        (mem_delay),
    .mem_req_val  (mem_req_val),
    .mem_req      (mem_req),
    .mem_credit   (mem_credit),
    .mem_resp_val (mem_resp_val),
    .mem_resp     (mem_resp),
    .outstanding  (outstanding),
    .op_err       (op_err)
  );

  // --------------------------------------------------
  // Helpers
  // --------------------------------------------------
  task automatic abort_run(input string line);
    $display("%s", line);
    $display("Test failures found");
    $fatal(1, "run stopped at first error");
  endtask

  // PC of the k-th fetched instruction
  function automatic logic [31:0] expect_pc(input int k);
    return `FETCH_RESET_PC + 32'(k) * 32'd4;
  endfunction

  // Image word at a PC, wrapping on the image size
  function automatic logic [31:0] expect_inst(input logic [31:0] pc);
    logic [31:0] word;
    word = (pc - `FETCH_RESET_PC) / 32'd4;
    return trace_mem[IMG_BASE + int'(word % 32'(IMG_WORDS))];
  endfunction

  task automatic check_decode(input f2d_t msg, input int k);
    logic [31:0] pc;
    pc = expect_pc(k);
    assert (msg.pc == pc)
      else abort_run($sformatf("[FAIL] %0t ns: decode %0d pc %h, expected %h",
                               $time, k, msg.pc, pc));
    assert (msg.inst == expect_inst(pc))
      else abort_run($sformatf("[FAIL] %0t ns: decode %0d inst %h, expected %h",
                               $time, k, msg.inst, expect_inst(pc)));
    // Seq wraps on its own width
    assert (msg.seq == SEQ_NUM_BITS'(k))
      else abort_run($sformatf("[FAIL] %0t ns: decode %0d seq %0d, expected %0d",
                               $time, k, msg.seq, SEQ_NUM_BITS'(k)));
  endtask

  // Header, phase rows, then image with random fill past the defined words
  task automatic load_trace();
    int img_defined;
    int max_delay;
    for (int i = 0; i < TRACE_WORDS; i++) begin
      trace_mem[i] = '0;
    end
    $readmemh("dv/fetch_trace.txt", trace_mem);
    n_phases    = int'(trace_mem[0]);
    img_defined = int'(trace_mem[1]);
    if (n_phases < 1 || n_phases > MAX_PHASES || img_defined > IMG_WORDS) begin
      abort_run("Trace header is malformed or could not be read");
    end
    max_delay = 1;
    for (int p = 0; p < n_phases; p++) begin
      total       = total + int'(trace_mem[2 + 4 * p]);
      ph_end[p]   = total;
      ph_delay[p] = int'(trace_mem[3 + 4 * p]);
      ph_dgap[p]  = int'(trace_mem[4 + 4 * p]);
      ph_cgap[p]  = int'(trace_mem[5 + 4 * p]);
      if (ph_delay[p] > max_delay) begin
        max_delay = ph_delay[p];
      end
    end
    for (int i = 0; i < IMG_WORDS; i++) begin
      if (i >= img_defined) begin
        trace_mem[IMG_BASE + i] = $urandom() ^ (`FETCH_RESET_PC + 32'(4 * i));
      end
      mem_i.img[i] = trace_mem[IMG_BASE + i];
    end
    limit = total * max_delay * 20;
  endtask

  // --------------------------------------------------
  // Clock, reset, end of run
  // --------------------------------------------------
  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  initial begin
    void'($urandom(32'he2c8_5aa3));
    arst_n = 1'b0;
    load_trace();
    // Both valids quiet through reset
    repeat (8) begin
      @(negedge clk);
      assert (!dec_val && !mem_req_val)
        else abort_run($sformatf("[FAIL] %0t ns: valid high during reset", $time));
    end
    arst_n = 1'b1;
    wait (dec_cnt >= total && com_cnt >= total);
    repeat (4) @(negedge clk);
    $display("All tests passed!");
    $finish;
  end

  // Phase follows the decode count
  always @(posedge clk) begin
    if (phase < n_phases - 1 && dec_cnt >= ph_end[phase]) begin
      phase <= phase + 1;
    end
    mem_delay <= ph_delay[phase];
  end

  // --------------------------------------------------
  // Decode sink, credit return, commit source
  // --------------------------------------------------
  always @(negedge clk) begin
    if (arst_n) begin
      if (dec_val) begin
        check_decode(dec_msg, dec_cnt);
        commit_q.push_back(dec_msg.seq);
        dec_cnt   = dec_cnt + 1;
        cred_owed = cred_owed + 1;
        assert (dec_cnt <= cred_back + DEC_CREDITS)
          else abort_run($sformatf("[FAIL] %0t ns: %0d decodes on %0d credits",
                                   $time, dec_cnt, cred_back + DEC_CREDITS));
        assert (dec_cnt - com_cnt <= SEQ_SPACE)
          else abort_run($sformatf("[FAIL] %0t ns: %0d uncommitted, limit %0d",
                                   $time, dec_cnt - com_cnt, SEQ_SPACE));
      end
      // Slot drained after the phase gap
      dec_credit = 1'b0;
      if (cred_owed != 0) begin
        if (dgap_cnt >= ph_dgap[phase]) begin
          dec_credit = 1'b1;
          cred_owed  = cred_owed - 1;
          cred_back  = cred_back + 1;
          dgap_cnt   = 0;
        end else begin
          dgap_cnt = dgap_cnt + 1;
        end
      end
      // In-order commits, paced per phase
      commit_val = 1'b0;
      if (commit_q.size() != 0) begin
        if (cgap_cnt >= ph_cgap[phase]) begin
          commit_val     = 1'b1;
          commit_msg.seq = commit_q.pop_front();
          com_cnt        = com_cnt + 1;
          cgap_cnt       = 0;
        end else begin
          cgap_cnt = cgap_cnt + 1;
        end
      end
    end
  end

  // Request stream walks from the reset PC, tag is the request count
  always @(negedge clk) begin
    if (arst_n && mem_req_val) begin
      assert (mem_req.addr == expect_pc(req_cnt))
        else abort_run($sformatf("[FAIL] %0t ns: request %0d addr %h, expected %h",
                                 $time, req_cnt, mem_req.addr, expect_pc(req_cnt)));
      assert (mem_req.opaq == MEM_OPAQ_BITS'(req_cnt))
        else abort_run($sformatf("[FAIL] %0t ns: request %0d tag %h, expected %h",
                                 $time, req_cnt, mem_req.opaq,
                                 MEM_OPAQ_BITS'(req_cnt)));
      req_cnt = req_cnt + 1;
    end
  end

  // Memory side limits, stable on the rising edge
  always @(posedge clk) begin
    if (arst_n) begin
      assert (outstanding <= MEM_CREDITS)
        else abort_run($sformatf("[FAIL] %0t ns: %0d requests outstanding, limit %0d",
                                 $time, outstanding, MEM_CREDITS));
      assert (!op_err)
        else abort_run($sformatf("[FAIL] %0t ns: memory request was not a read", $time));
    end
  end

  initial begin
    wait (limit > 0);
    repeat (limit) @(posedge clk);
    abort_run($sformatf("Watchdog expired after %0d cycles with %0d of %0d decoded",
                        limit, dec_cnt, total));
  end

endmodule

// File: fetch_unit.f
+incdir+include
hw/mem_pkg.sv
hw/fetch_pkg.sv
hw/fetch_pc_gen.sv
hw/seq_num_tracker.sv
hw/fetch_resp_buffer.sv
hw/fetch_unit.sv
dv/fetch_mem_model.sv
dv/fetch_unit_tb.sv

// File: hw/fetch_pc_gen.sv
/*
 * Fetch PC generator
 * Walks the PC from the reset address, issues memory reads under
 * memory credits and sequence-number availability
 */
`timescale 1ns/1ps
`include "fetch_defs.svh"

module fetch_pc_gen
  import mem_pkg::*;
  import fetch_pkg::*;
#(
  parameter int MEM_CREDITS  = `FETCH_MEM_CREDITS,
  parameter int SEQ_NUM_BITS = `FETCH_SEQ_NUM_BITS
) (
  input  logic                    clk,
  input  logic                    arst_n,
  input  logic                    mem_credit,
  input  logic                    alloc_ok,
  input  logic [SEQ_NUM_BITS-1:0] alloc_seq,
  output logic                    alloc_req,
  output logic                    mem_req_val,
  output mem_req_t                mem_req,
  output logic                    issue_val,
  output logic [31:0]             issue_pc,
  output logic [SEQ_NUM_BITS-1:0] issue_seq
);

  localparam int CRED_BITS = $clog2(MEM_CREDITS + 1);

  fetch_state_e             state_q;
  logic [31:0]              pc_q;
  logic [CRED_BITS-1:0]     cred_q;
  logic [MEM_OPAQ_BITS-1:0] req_cnt_q;
  logic                     fire;

  // --------------------------------------------------
  // Issue decision
  // --------------------------------------------------
  // Ask for a number only when a request could go out
  assign alloc_req = (state_q == FETCH_RUN) && (cred_q != '0);
  // Tracker grants in the same cycle
  assign fire = alloc_req && alloc_ok;

  assign mem_req_val  = fire;
  assign mem_req.op   = MEM_READ;
  // Tag is the low bits of the request count
  assign mem_req.opaq = req_cnt_q;
  assign mem_req.addr = pc_q;

  // Same beat goes to the response buffer
  assign issue_val = fire;
  assign issue_pc  = pc_q;
  assign issue_seq = alloc_seq;

  // --------------------------------------------------
  // FSM and PC
  // --------------------------------------------------
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state_q   <= FETCH_IDLE;
      pc_q      <= FETCH_PC_RESET;
      req_cnt_q <= '0;
    end else begin
      // Leave IDLE on the first clock after reset
      if (state_q == FETCH_IDLE) begin
        state_q <= FETCH_RUN;
      end
      if (fire) begin
        pc_q      <= fetch_pc_next(pc_q);
        req_cnt_q <= req_cnt_q + 1'b1;
      end
    end
  end

  // --------------------------------------------------
  // Memory credits
  // --------------------------------------------------
  // Return and spend may land in the same cycle
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      cred_q <= CRED_BITS'(MEM_CREDITS);
    end else begin
      cred_q <= cred_q + CRED_BITS'(mem_credit) - CRED_BITS'(fire);
    end
  end

  // Memory never hands back more than it was given
  a_cred_bound: assert property (@(posedge clk) disable iff (!arst_n)
    int'(cred_q) <= MEM_CREDITS)
    else $error("fetch_pc_gen: memory credits above %0d", MEM_CREDITS);

  // A return into a full counter would wrap it
  a_cred_return: assert property (@(posedge clk) disable iff (!arst_n)
    mem_credit |-> (int'(cred_q) < MEM_CREDITS) || fire)
    else $error("fetch_pc_gen: credit returned with counter full");

endmodule

// File: hw/fetch_pkg.sv
/*
 * Fetch package
 * PC generator states and PC sequencing constants; the decode and
 * commit struct macros come in with the shared defines
 */
`include "fetch_defs.svh"

package fetch_pkg;

  // --------------------------------------------------
  // PC sequencing
  // --------------------------------------------------
  // First fetched address
  localparam logic [31:0] FETCH_PC_RESET = `FETCH_RESET_PC;

  // One 32-bit instruction per fetch, no branches
  localparam logic [31:0] FETCH_PC_STEP = 32'd4;

  // --------------------------------------------------
  // Generator FSM
  // --------------------------------------------------
  // IDLE only while held in reset
  // RUN from the first clock after release
  typedef enum logic {
    FETCH_IDLE = 1'b0,
    FETCH_RUN  = 1'b1
  } fetch_state_e;

  // --------------------------------------------------
  // Helpers
  // --------------------------------------------------
  // Sequential next PC
  function automatic logic [31:0] fetch_pc_next(input logic [31:0] pc);
    logic [31:0] nxt;
    nxt = pc + FETCH_PC_STEP;
    return nxt;
  endfunction

endpackage

// File: hw/fetch_resp_buffer.sv
/*
 * Fetch response buffer
 * Matches in-order memory responses to issued PC and sequence
 * pairs and sends them to decode under decode credits
 */
`timescale 1ns/1ps
`include "fetch_defs.svh"

module fetch_resp_buffer
  import mem_pkg::*;
#(
  parameter int MEM_CREDITS  = `FETCH_MEM_CREDITS,
  parameter int DEC_CREDITS  = `FETCH_DEC_CREDITS,
  parameter int SEQ_NUM_BITS = `FETCH_SEQ_NUM_BITS
) (
  input  logic                           clk,
  input  logic                           arst_n,
  input  logic                           issue_val,
  input  logic [31:0]                    issue_pc,
  input  logic [SEQ_NUM_BITS-1:0]        issue_seq,
  input  logic                           mem_resp_val,
  input  mem_resp_t                      mem_resp,
  input  logic                           dec_credit,
  output logic                           dec_val,
  output `FETCH_F2D_T(SEQ_NUM_BITS)      dec_msg
);

  // Ring covers every number that can be in flight
  localparam int DEPTH      = 2 ** SEQ_NUM_BITS;
  localparam int CNT_BITS   = SEQ_NUM_BITS + 1;
  localparam int DCRED_BITS = $clog2(DEC_CREDITS + 1);

  typedef `FETCH_F2D_T(SEQ_NUM_BITS) f2d_t;

  // --------------------------------------------------
  // Storage
  // --------------------------------------------------
  // One ring, two regions
  // Pending is resp_ptr..wr_ptr, waiting on memory
  // Ready is rd_ptr..resp_ptr, waiting on decode credit
  f2d_t                     entry_q [DEPTH];
  logic [SEQ_NUM_BITS-1:0]  wr_ptr_q;
  logic [SEQ_NUM_BITS-1:0]  resp_ptr_q;
  logic [SEQ_NUM_BITS-1:0]  rd_ptr_q;
  logic [CNT_BITS-1:0]      pend_cnt_q;
  logic [CNT_BITS-1:0]      rdy_cnt_q;
  logic [MEM_OPAQ_BITS-1:0] exp_tag_q;
  logic [DCRED_BITS-1:0]    dec_cred_q;

  always_ff @(posedge clk) begin
    if (issue_val) begin
      entry_q[wr_ptr_q].pc  <= issue_pc;
      entry_q[wr_ptr_q].seq <= issue_seq;
    end
    // Head of pending gets its instruction word
    if (mem_resp_val) begin
      entry_q[resp_ptr_q].inst <= mem_resp.data;
    end
  end

  // --------------------------------------------------
  // Decode side
  // --------------------------------------------------
  // Registered ready region, so one cycle after the response
  assign dec_val = (rdy_cnt_q != '0) && (dec_cred_q != '0);
  assign dec_msg = entry_q[rd_ptr_q];

  // --------------------------------------------------
  // Pointers, counts, credits
  // --------------------------------------------------
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      wr_ptr_q   <= '0;
      resp_ptr_q <= '0;
      rd_ptr_q   <= '0;
      pend_cnt_q <= '0;
      rdy_cnt_q  <= '0;
      exp_tag_q  <= '0;
      dec_cred_q <= DCRED_BITS'(DEC_CREDITS);
    end else begin
      if (issue_val) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      // Responses come back in request order
      if (mem_resp_val) begin
        resp_ptr_q <= resp_ptr_q + 1'b1;
        exp_tag_q  <= exp_tag_q + 1'b1;
      end
      if (dec_val) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      pend_cnt_q <= pend_cnt_q + CNT_BITS'(issue_val) - CNT_BITS'(mem_resp_val);
      rdy_cnt_q  <= rdy_cnt_q + CNT_BITS'(mem_resp_val) - CNT_BITS'(dec_val);
      dec_cred_q <= dec_cred_q + DCRED_BITS'(dec_credit) - DCRED_BITS'(dec_val);
    end
  end

  // --------------------------------------------------
  // Checks
  // --------------------------------------------------
  // Response must belong to the oldest pending request
  a_tag_match: assert property (@(posedge clk) disable iff (!arst_n)
    mem_resp_val |-> (pend_cnt_q != '0) && (mem_resp.opaq == exp_tag_q))
    else $error("fetch_resp_buffer: tag %0h, expected %0h",
                mem_resp.opaq, exp_tag_q);

  // Memory credits bound the pending region
  a_pend_bound: assert property (@(posedge clk) disable iff (!arst_n)
    int'(pend_cnt_q) <= MEM_CREDITS)
    else $error("fetch_resp_buffer: pending region overflow");

  // Sequence space bounds the whole ring
  a_ring_bound: assert property (@(posedge clk) disable iff (!arst_n)
    (int'(pend_cnt_q) + int'(rdy_cnt_q)) <= DEPTH)
    else $error("fetch_resp_buffer: ring overflow");

endmodule

// File: hw/fetch_unit.sv
/*
 * Instruction fetch unit
 * Connects the PC generator, sequence number tracker and
 * response buffer
 */
`timescale 1ns/1ps
`include "fetch_defs.svh"

module fetch_unit
  import mem_pkg::*;
#(
  parameter int SEQ_NUM_BITS = `FETCH_SEQ_NUM_BITS,
  parameter int MEM_CREDITS  = `FETCH_MEM_CREDITS,
  parameter int DEC_CREDITS  = `FETCH_DEC_CREDITS
) (
  input  logic                           clk,
  input  logic                           arst_n,
  // Memory port
  output logic                           mem_req_val,
  output mem_req_t                       mem_req,
  input  logic                           mem_credit,
  input  logic                           mem_resp_val,
  input  mem_resp_t                      mem_resp,
  // Decode port
  output logic                           dec_val,
  output `FETCH_F2D_T(SEQ_NUM_BITS)      dec_msg,
  input  logic                           dec_credit,
  // Commit notifications
  input  logic                           commit_val,
  input  `FETCH_COMMIT_T(SEQ_NUM_BITS)   commit_msg
);

  // --------------------------------------------------
  // Internal links
  // --------------------------------------------------
  logic                    alloc_req;
  logic                    alloc_ok;
  logic [SEQ_NUM_BITS-1:0] alloc_seq;
  logic                    issue_val;
  logic [31:0]             issue_pc;
  logic [SEQ_NUM_BITS-1:0] issue_seq;

  // PC walk and request issue
  fetch_pc_gen #(
    .MEM_CREDITS  (MEM_CREDITS),
    .SEQ_NUM_BITS (SEQ_NUM_BITS)
  ) pc_gen_i (
    .clk         (clk),
    .arst_n      (arst_n),
    .mem_credit  (mem_credit),
    .alloc_ok    (alloc_ok),
    .alloc_seq   (alloc_seq),
    .alloc_req   (alloc_req),
    .mem_req_val (mem_req_val),
    .mem_req     (mem_req),
    .issue_val   (issue_val),
    .issue_pc    (issue_pc),
    .issue_seq   (issue_seq)
  );

  // Sequence number allocation and commit release
  seq_num_tracker #(
    .SEQ_NUM_BITS (SEQ_NUM_BITS)
  ) tracker_i (
    .clk        (clk),
    .arst_n     (arst_n),
    .alloc_req  (alloc_req),
    .alloc_ok   (alloc_ok),
    .alloc_seq  (alloc_seq),
    .commit_val (commit_val),
    .commit_msg (commit_msg)
  );

  // Response pairing and decode delivery
  fetch_resp_buffer #(
    .MEM_CREDITS  (MEM_CREDITS),
    .DEC_CREDITS  (DEC_CREDITS),
    .SEQ_NUM_BITS (SEQ_NUM_BITS)
  ) resp_buf_i (
    .clk          (clk),
    .arst_n       (arst_n),
    .issue_val    (issue_val),
    .issue_pc     (issue_pc),
    .issue_seq    (issue_seq),
    .mem_resp_val (mem_resp_val),
    .mem_resp     (mem_resp),
    .dec_credit   (dec_credit),
    .dec_val      (dec_val),
    .dec_msg      (dec_msg)
  );

endmodule

// File: hw/mem_pkg.sv
/*
 * Memory port package
 * Opcode enum and request and response structs of the instruction
 * memory port
 */
`include "fetch_defs.svh"

package mem_pkg;

  // --------------------------------------------------
  // Widths
  // --------------------------------------------------
  // Opaque tag carried from request to response
  localparam int MEM_OPAQ_BITS = `FETCH_OPAQ_BITS;

  // --------------------------------------------------
  // Opcodes
  // --------------------------------------------------
  // Writes exist on the port type, fetch only reads
  typedef enum logic {
    MEM_READ  = 1'b0,
    MEM_WRITE = 1'b1
  } mem_op_e;

  // --------------------------------------------------
  // Messages
  // --------------------------------------------------
  typedef struct packed {
    mem_op_e                  op;
    logic [MEM_OPAQ_BITS-1:0] opaq;
    logic [31:0]              addr;
  } mem_req_t;

  // Data is the full instruction word
  typedef struct packed {
    logic [MEM_OPAQ_BITS-1:0] opaq;
    logic [31:0]              data;
  } mem_resp_t;

endpackage

// File: hw/seq_num_tracker.sv
/*
 * Sequence number tracker
 * Hands out sequence numbers in wrapping order and frees the
 * oldest one on each commit
 */
`timescale 1ns/1ps
`include "fetch_defs.svh"

module seq_num_tracker #(
  parameter int SEQ_NUM_BITS = `FETCH_SEQ_NUM_BITS
) (
  input  logic                              clk,
  input  logic                              arst_n,
  input  logic                              alloc_req,
  output logic                              alloc_ok,
  output logic [SEQ_NUM_BITS-1:0]           alloc_seq,
  input  logic                              commit_val,
  input  `FETCH_COMMIT_T(SEQ_NUM_BITS)      commit_msg
);

  localparam int DEPTH    = 2 ** SEQ_NUM_BITS;
  localparam int CNT_BITS = SEQ_NUM_BITS + 1;

  logic [SEQ_NUM_BITS-1:0] alloc_ptr_q;
  logic [SEQ_NUM_BITS-1:0] free_ptr_q;
  logic [CNT_BITS-1:0]     count_q;
  logic                    full;

  // --------------------------------------------------
  // Allocation
  // --------------------------------------------------
  // All numbers in flight once count hits DEPTH
  assign full      = (count_q == CNT_BITS'(DEPTH));
  assign alloc_ok  = alloc_req && !full;
  assign alloc_seq = alloc_ptr_q;

  // --------------------------------------------------
  // Pointers and occupancy
  // --------------------------------------------------
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      alloc_ptr_q <= '0;
      free_ptr_q  <= '0;
      count_q     <= '0;
    end else begin
      // Pointers wrap on their own width
      if (alloc_ok) begin
        alloc_ptr_q <= alloc_ptr_q + 1'b1;
      end
      // In-order commit frees the oldest
      if (commit_val) begin
        free_ptr_q <= free_ptr_q + 1'b1;
      end
      count_q <= count_q + CNT_BITS'(alloc_ok) - CNT_BITS'(commit_val);
    end
  end

  // --------------------------------------------------
  // Checks
  // --------------------------------------------------
  // Commit source must follow decode order
  a_commit_oldest: assert property (@(posedge clk) disable iff (!arst_n)
    commit_val |-> (count_q != '0) && (commit_msg.seq == free_ptr_q))
    else $error("seq_num_tracker: commit seq %0d, oldest %0d, in flight %0d",
                commit_msg.seq, free_ptr_q, count_q);

endmodule

// File: include/fetch_defs.svh
/*
 * Fetch subsystem shared defines
 * Reset PC, default widths and credit counts, and type macros for
 * structs whose width follows the sequence-number parameter
 */
`ifndef FETCH_DEFS_SVH
`define FETCH_DEFS_SVH

// --------------------------------------------------
// Reset PC and defaults
// --------------------------------------------------
`define FETCH_RESET_PC      32'h0000_0200
`define FETCH_OPAQ_BITS     8
`define FETCH_SEQ_NUM_BITS  4
`define FETCH_MEM_CREDITS   4
`define FETCH_DEC_CREDITS   2

// --------------------------------------------------
// Struct macros sized by SEQ_NUM_BITS
// --------------------------------------------------
// Fetch to decode message
`define FETCH_F2D_T(SB) \
  struct packed { \
    logic [31:0]     inst; \
    logic [31:0]     pc; \
    logic [(SB)-1:0] seq; \
  }

// Commit notification, seq only
`define FETCH_COMMIT_T(SB) \
  struct packed { \
    logic [(SB)-1:0] seq; \
  }

`endif

// File: run_sim.sh
#!/bin/sh
# Build and run the fetch_unit testbench with Verilator
cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
TOP=fetch_unit_tb

if ! command -v verilator >/dev/null 2>&1; then
  echo "verilator not found on PATH"
  exit 1
fi

verilator --binary --timing --assert \
  --top-module "$TOP" \
  --Mdir "$BUILD_DIR" \
  -o "$TOP" \
  -f fetch_unit.f
status=$?
if [ "$status" -ne 0 ]; then
  echo "Build failed with status $status"
  exit "$status"
fi

"./$BUILD_DIR/$TOP"
status=$?
if [ "$status" -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit "$status"
fi
exit 0
